/* Makefile */
SIM_BIN = obj_dir/sim_core
LOG     = sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --timescale 1ns/1ns -f tb.f \
		--top-module tb_core -Mdir obj_dir -o sim_core

run: compile
	./$(SIM_BIN) > $(LOG) 2>&1; cat $(LOG)
	grep -q "All tests passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

/* hw/core_config.svh */
`ifndef CORE_CONFIG_SVH
`define CORE_CONFIG_SVH

`define CORE_XLEN       32
`define CORE_NREGS      32

// base opcodes
`define CORE_OP_REG     7'b0110011
`define CORE_OP_IMM     7'b0010011
`define CORE_OP_LUI     7'b0110111

// funct3 / funct7 of the kept alu ops
`define CORE_F3_ADD     3'b000
`define CORE_F3_SLT     3'b010
`define CORE_F3_XOR     3'b100
`define CORE_F3_OR      3'b110
`define CORE_F3_AND     3'b111
`define CORE_F7_BASE    7'b0000000
`define CORE_F7_SUB     7'b0100000

`endif

/* hw/core_pkg.sv */
`include "core_config.svh"

package core_pkg;

    typedef logic [`CORE_XLEN-1:0] xlen_t;
    typedef logic [4:0] reg_addr_t;

    // PASS_B serves lui
    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_PASS_B
    } alu_op_t;

    // rs1/rs2 are zero when the instruction does not read them
    typedef struct packed {
        alu_op_t   alu_op;
        logic      op2_is_imm;
        logic      rf_wen;
        reg_addr_t rs1;
        reg_addr_t rs2;
        reg_addr_t rd;
    } ctrl_t;

    typedef struct packed {
        ctrl_t ctrl;
        xlen_t imm;
    } id_ds_t;

    typedef struct packed {
        ctrl_t ctrl;
        xlen_t op1;
        xlen_t op2;
    } ds_exe_t;

    typedef struct packed {
        reg_addr_t rd;
        logic      rf_wen;
        xlen_t     result;
    } exe_wb_t;

    typedef struct packed {
        reg_addr_t rd;
        logic      wen;
        xlen_t     wdata;
    } retire_t;

    typedef logic [`CORE_NREGS-1:0][`CORE_XLEN-1:0] regs_t;

endpackage

/* hw/core_top.sv */
`timescale 1ns/1ns

module core_top (
    input  logic              clk,
    input  logic              reset_i,
    input  logic              inst_valid_i,
    input  logic [31:0]       inst_i,
    output logic              inst_ready_o,
    output logic              retire_valid_o,
    output core_pkg::retire_t retire_o,
    output core_pkg::xlen_t   gp_o
);

    logic              hazard_stall;
    logic              id_valid;
    core_pkg::id_ds_t  id_ds;
    logic              ds_valid;
    core_pkg::id_ds_t  ds_q;
    core_pkg::ds_exe_t ds_exe;
    logic              exe_valid;
    core_pkg::ds_exe_t exe_q;
    core_pkg::exe_wb_t exe_wb;
    logic              wb_valid;
    core_pkg::exe_wb_t wb_q;
    core_pkg::regs_t   regs;

    decode_unit u_decode (
        .clk            (clk),
        .reset_i        (reset_i),
        .inst_valid_i   (inst_valid_i),
        .inst_i         (inst_i),
        .hazard_stall_i (hazard_stall),
        .inst_ready_o   (inst_ready_o),
        .id_valid_o     (id_valid),
        .id_o           (id_ds)
    );

    // ds holds on a hazard
    pipe_stage_reg #(.payload_t(core_pkg::id_ds_t)) u_ds_reg (
        .clk        (clk),
        .reset_i    (reset_i),
        .hold_i     (hazard_stall),
        .bubble_i   (1'b0),
        .in_valid_i (id_valid),
        .in_i       (id_ds),
        .valid_o    (ds_valid),
        .out_o      (ds_q)
    );

    operand_select u_opsel (
        .ds_valid_i     (ds_valid),
        .ds_i           (ds_q),
        .exe_valid_i    (exe_valid),
        .exe_ctrl_i     (exe_q.ctrl),
        .wb_valid_i     (wb_valid),
        .wb_i           (wb_q),
        .regs_i         (regs),
        .hazard_stall_o (hazard_stall),
        .ds_exe_o       (ds_exe)
    );

    // exe takes a bubble on a hazard
    pipe_stage_reg #(.payload_t(core_pkg::ds_exe_t)) u_exe_reg (
        .clk        (clk),
        .reset_i    (reset_i),
        .hold_i     (1'b0),
        .bubble_i   (hazard_stall),
        .in_valid_i (ds_valid),
        .in_i       (ds_exe),
        .valid_o    (exe_valid),
        .out_o      (exe_q)
    );

    execute_unit u_exe (
        .exe_i    (exe_q),
        .exe_wb_o (exe_wb)
    );

    pipe_stage_reg #(.payload_t(core_pkg::exe_wb_t)) u_wb_reg (
        .clk        (clk),
        .reset_i    (reset_i),
        .hold_i     (1'b0),
        .bubble_i   (1'b0),
        .in_valid_i (exe_valid),
        .in_i       (exe_wb),
        .valid_o    (wb_valid),
        .out_o      (wb_q)
    );

    writeback_regfile u_wb (
        .clk            (clk),
        .reset_i        (reset_i),
        .wb_valid_i     (wb_valid),
        .wb_i           (wb_q),
        .regs_o         (regs),
        .retire_valid_o (retire_valid_o),
        .retire_o       (retire_o),
        .gp_o           (gp_o)
    );

endmodule

/* hw/decode_unit.sv */
`timescale 1ns/1ns

`include "core_config.svh"

module decode_unit (
    input  logic             clk,
    input  logic             reset_i,
    input  logic             inst_valid_i,
    input  logic [31:0]      inst_i,
    input  logic             hazard_stall_i,
    output logic             inst_ready_o,
    output logic             id_valid_o,
    output core_pkg::id_ds_t id_o
);

    logic                id_valid_q;
    logic [31:0]         id_inst_q;
    logic [6:0]          opcode;
    logic [2:0]          funct3;
    logic [6:0]          funct7;
    logic                supported;
    logic                use_rs1;
    logic                use_rs2;
    logic                op2_is_imm;
    core_pkg::alu_op_t   alu_op;
    core_pkg::reg_addr_t rd;

    // blocked only while a valid word cannot move on
    assign inst_ready_o = !(id_valid_q && hazard_stall_i);

    always_ff @(posedge clk) begin
        if (reset_i) begin
            id_valid_q <= 1'b0;
        end else if (inst_ready_o) begin
            id_valid_q <= inst_valid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (inst_valid_i && inst_ready_o) begin
            id_inst_q <= inst_i;
        end
    end

    assign opcode = id_inst_q[6:0];
    assign funct3 = id_inst_q[14:12];
    assign funct7 = id_inst_q[31:25];
    assign rd     = id_inst_q[11:7];

    always_comb begin
        supported  = 1'b0;
        use_rs1    = 1'b0;
        use_rs2    = 1'b0;
        op2_is_imm = 1'b0;
        alu_op     = core_pkg::ALU_ADD;
        case (opcode)
            `CORE_OP_REG: begin
                use_rs1   = 1'b1;
                use_rs2   = 1'b1;
                supported = (funct7 == `CORE_F7_BASE);
                case (funct3)
                    `CORE_F3_ADD: begin
                        if (funct7 == `CORE_F7_SUB) begin
                            supported = 1'b1;
                            alu_op    = core_pkg::ALU_SUB;
                        end
                    end
                    `CORE_F3_SLT: alu_op = core_pkg::ALU_SLT;
                    `CORE_F3_XOR: alu_op = core_pkg::ALU_XOR;
                    `CORE_F3_OR:  alu_op = core_pkg::ALU_OR;
                    `CORE_F3_AND: alu_op = core_pkg::ALU_AND;
                    default:      supported = 1'b0;
                endcase
            end
            `CORE_OP_IMM: begin
                use_rs1    = 1'b1;
                op2_is_imm = 1'b1;
                supported  = 1'b1;
                case (funct3)
                    `CORE_F3_ADD: alu_op = core_pkg::ALU_ADD;
                    `CORE_F3_XOR: alu_op = core_pkg::ALU_XOR;
                    `CORE_F3_OR:  alu_op = core_pkg::ALU_OR;
                    `CORE_F3_AND: alu_op = core_pkg::ALU_AND;
                    // slti and shifts are not kept
                    default:      supported = 1'b0;
                endcase
            end
            `CORE_OP_LUI: begin
                op2_is_imm = 1'b1;
                supported  = 1'b1;
                alu_op     = core_pkg::ALU_PASS_B;
            end
            default: supported = 1'b0;
        endcase
    end

    // unsupported words become bubbles that read and write nothing
    always_comb begin
        id_o.ctrl.alu_op     = alu_op;
        id_o.ctrl.op2_is_imm = op2_is_imm;
        id_o.ctrl.rf_wen     = supported && (rd != '0);
        id_o.ctrl.rs1        = (supported && use_rs1) ? id_inst_q[19:15] : '0;
        id_o.ctrl.rs2        = (supported && use_rs2) ? id_inst_q[24:20] : '0;
        id_o.ctrl.rd         = supported ? rd : '0;
        if (opcode == `CORE_OP_LUI) begin
            id_o.imm = {id_inst_q[31:12], 12'b0};
        end else begin
            id_o.imm = {{20{id_inst_q[31]}}, id_inst_q[31:20]};
        end
    end

    assign id_valid_o = id_valid_q;

endmodule

/* hw/execute_unit.sv */
`timescale 1ns/1ns

module execute_unit (
    input  core_pkg::ds_exe_t exe_i,
    output core_pkg::exe_wb_t exe_wb_o
);

    core_pkg::xlen_t result;
    logic            less_signed;

    assign less_signed = $signed(exe_i.op1) < $signed(exe_i.op2);

    always_comb begin
        case (exe_i.ctrl.alu_op)
            core_pkg::ALU_ADD: begin
                result = exe_i.op1 + exe_i.op2;
            end
            core_pkg::ALU_SUB: begin
                result = exe_i.op1 - exe_i.op2;
            end
            core_pkg::ALU_AND: begin
                result = exe_i.op1 & exe_i.op2;
            end
            core_pkg::ALU_OR: begin
                result = exe_i.op1 | exe_i.op2;
            end
            core_pkg::ALU_XOR: begin
                result = exe_i.op1 ^ exe_i.op2;
            end
            core_pkg::ALU_SLT: begin
                result = core_pkg::xlen_t'(less_signed);
            end
            // lui immediate is already shifted in decode
            core_pkg::ALU_PASS_B: begin
                result = exe_i.op2;
            end
            default: begin
                result = '0;
            end
        endcase
    end

    assign exe_wb_o.rd     = exe_i.ctrl.rd;
    assign exe_wb_o.rf_wen = exe_i.ctrl.rf_wen;
    assign exe_wb_o.result = result;

endmodule

/* hw/operand_select.sv */
`timescale 1ns/1ns

module operand_select (
    input  logic              ds_valid_i,
    input  core_pkg::id_ds_t  ds_i,
    input  logic              exe_valid_i,
    input  core_pkg::ctrl_t   exe_ctrl_i,
    input  logic              wb_valid_i,
    input  core_pkg::exe_wb_t wb_i,
    input  core_pkg::regs_t   regs_i,
    output logic              hazard_stall_o,
    output core_pkg::ds_exe_t ds_exe_o
);

    logic            exe_writes;
    logic            rs1_hit;
    logic            rs2_hit;
    core_pkg::xlen_t rs1_val;
    core_pkg::xlen_t rs2_val;

    // exe result is too late to forward, so a match there costs a cycle
    assign exe_writes = exe_valid_i && exe_ctrl_i.rf_wen && (exe_ctrl_i.rd != '0);

    assign rs1_hit = (ds_i.ctrl.rs1 != '0) && (ds_i.ctrl.rs1 == exe_ctrl_i.rd);
    assign rs2_hit = !ds_i.ctrl.op2_is_imm && (ds_i.ctrl.rs2 != '0) &&
                     (ds_i.ctrl.rs2 == exe_ctrl_i.rd);

    assign hazard_stall_o = ds_valid_i && exe_writes && (rs1_hit || rs2_hit);

    // x0 first, then wb bypass, then the register file
    function automatic core_pkg::xlen_t read_reg(
        input core_pkg::reg_addr_t addr,
        input logic                wb_valid,
        input core_pkg::exe_wb_t   wb,
        input core_pkg::regs_t     regs
    );
        core_pkg::xlen_t value;
        if (addr == '0) begin
            value = '0;
        end else if (wb_valid && wb.rf_wen && (wb.rd == addr)) begin
            value = wb.result;
        end else begin
            value = regs[addr];
        end
        return value;
    endfunction

    always_comb begin
        rs1_val = read_reg(ds_i.ctrl.rs1, wb_valid_i, wb_i, regs_i);
        rs2_val = read_reg(ds_i.ctrl.rs2, wb_valid_i, wb_i, regs_i);
    end

    always_comb begin
        ds_exe_o.ctrl = ds_i.ctrl;
        ds_exe_o.op1  = rs1_val;
        if (ds_i.ctrl.op2_is_imm) begin
            ds_exe_o.op2 = ds_i.imm;
        end else begin
            ds_exe_o.op2 = rs2_val;
        end
    end

endmodule

/* hw/pipe_stage_reg.sv */
`timescale 1ns/1ns

module pipe_stage_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     reset_i,
    input  logic     hold_i,
    input  logic     bubble_i,
    input  logic     in_valid_i,
    input  payload_t in_i,
    output logic     valid_o,
    output payload_t out_o
);

    logic     valid_q;
    payload_t payload_q;

    // hold wins over bubble
    always_ff @(posedge clk) begin
        if (reset_i) begin
            valid_q <= 1'b0;
        end else if (!hold_i) begin
            valid_q <= in_valid_i && !bubble_i;
        end
    end

    always_ff @(posedge clk) begin
        if (!hold_i) begin
            payload_q <= in_i;
        end
    end

    assign valid_o = valid_q;
    assign out_o   = payload_q;

endmodule

/* hw/writeback_regfile.sv */
`timescale 1ns/1ns

module writeback_regfile (
    input  logic              clk,
    input  logic              reset_i,
    input  logic              wb_valid_i,
    input  core_pkg::exe_wb_t wb_i,
    output core_pkg::regs_t   regs_o,
    output logic              retire_valid_o,
    output core_pkg::retire_t retire_o,
    output core_pkg::xlen_t   gp_o
);

    core_pkg::regs_t regs_q;
    logic            wr_en;

    assign wr_en = wb_valid_i && wb_i.rf_wen && (wb_i.rd != '0);

    always_ff @(posedge clk) begin
        if (reset_i) begin
            regs_q <= '0;
        end else if (wr_en) begin
            regs_q[wb_i.rd] <= wb_i.result;
        end
    end

    assign regs_o = regs_q;

    // retire report lines up with the write edge
    assign retire_valid_o = wb_valid_i;
    assign retire_o.rd    = wb_i.rd;
    assign retire_o.wen   = wb_i.rf_wen;
    assign retire_o.wdata = wb_i.result;

    // x3 is gp
    assign gp_o = regs_q[3];

    // decode must already have dropped rf_wen for rd = x0
    a_no_x0_write: assert property (
        @(posedge clk) disable iff (reset_i)
        wb_valid_i && wb_i.rf_wen |-> wb_i.rd != '0
    ) else $error("write to x0 reached writeback");

endmodule

/* sim/core_checker.sv */
`timescale 1ns/1ns

`include "core_config.svh"

module core_checker (
    input  logic              clk,
    input  logic              reset_i,
    input  logic              inst_valid_i,
    input  logic [31:0]       inst_i,
    input  logic              inst_ready_i,
    input  core_pkg::retire_t table_exp_i,
    input  logic              retire_valid_i,
    input  core_pkg::retire_t retire_i,
    input  core_pkg::xlen_t   gp_i,
    input  logic              done_i,
    output int                pending_o,
    output int                value_errs_o,
    output int                other_errs_o,
    output int                accepted_o,
    output int                retired_o,
    output logic              checked_o
);

    core_pkg::xlen_t   model_regs [`CORE_NREGS];
    core_pkg::retire_t exp_q [$];
    logic              after_reset;
    int                stall_cycles;

    // reference model of the kept ISA, applied in program order
    function automatic core_pkg::retire_t predict(input logic [31:0] w);
        core_pkg::retire_t res;
        core_pkg::xlen_t   a;
        core_pkg::xlen_t   b;
        core_pkg::xlen_t   imm;
        core_pkg::xlen_t   val;
        logic              ok;
        a   = model_regs[w[19:15]];
        b   = model_regs[w[24:20]];
        imm = {{20{w[31]}}, w[31:20]};
        val = '0;
        ok  = 1'b1;
        case (w[6:0])
            `CORE_OP_REG: begin
                if (w[31:25] == `CORE_F7_SUB && w[14:12] == `CORE_F3_ADD) begin
                    val = a - b;
                end else if (w[31:25] != `CORE_F7_BASE) begin
                    ok = 1'b0;
                end else begin
                    case (w[14:12])
                        `CORE_F3_ADD: val = a + b;
                        `CORE_F3_SLT: val = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                        `CORE_F3_XOR: val = a ^ b;
                        `CORE_F3_OR:  val = a | b;
                        `CORE_F3_AND: val = a & b;
                        default:      ok = 1'b0;
                    endcase
                end
            end
            `CORE_OP_IMM: begin
                case (w[14:12])
                    `CORE_F3_ADD: val = a + imm;
                    `CORE_F3_XOR: val = a ^ imm;
                    `CORE_F3_OR:  val = a | imm;
                    `CORE_F3_AND: val = a & imm;
                    default:      ok = 1'b0;
                endcase
            end
            `CORE_OP_LUI: val = {w[31:12], 12'b0};
            default: ok = 1'b0;
        endcase
        res.wen   = ok && (w[11:7] != 5'd0);
        res.rd    = res.wen ? w[11:7] : 5'd0;
        res.wdata = res.wen ? val : '0;
        if (res.wen) begin
            model_regs[w[11:7]] = val;
        end
        return res;
    endfunction

    task automatic compare_value(input string name, input logic [31:0] exp,
                                 input logic [31:0] act);
        if (act !== exp) begin
            $display("ERR %0t %s expected %h actual %h", $time, name, exp, act);
            value_errs_o++;
        end
    endtask

    task automatic check_retire();
        core_pkg::retire_t exp;
        retired_o++;
        if (exp_q.size() == 0) begin
            $display("retire at %0t with no instruction outstanding", $time);
            other_errs_o++;
        end else begin
            exp = exp_q.pop_front();
            compare_value("retire_o.wen", 32'(exp.wen), 32'(retire_i.wen));
            // rd and data only matter for a real write
            if (exp.wen) begin
                compare_value("retire_o.rd", 32'(exp.rd), 32'(retire_i.rd));
                compare_value("retire_o.wdata", exp.wdata, retire_i.wdata);
            end
        end
    endtask

    task automatic accept_word();
        core_pkg::retire_t exp;
        exp = predict(inst_i);
        if (exp != table_exp_i) begin
            $display("model and table disagree on word %h: model %h, table %h",
                     inst_i, exp, table_exp_i);
            other_errs_o++;
        end
        exp_q.push_back(exp);
        accepted_o++;
    endtask

    task automatic final_checks();
        if (accepted_o != retired_o) begin
            $display("accepted %0d instructions but %0d retired", accepted_o, retired_o);
            other_errs_o++;
        end
        compare_value("gp_o", model_regs[3], gp_i);
        if (stall_cycles == 0) begin
            $display("inst_ready_o never dropped, so no hazard stall was seen");
            other_errs_o++;
        end
        checked_o = 1'b1;
    endtask

    always @(posedge clk) begin
        if (reset_i) begin
            foreach (model_regs[i]) begin
                model_regs[i] = '0;
            end
            exp_q.delete();
            value_errs_o = 0;
            other_errs_o = 0;
            accepted_o   = 0;
            retired_o    = 0;
            stall_cycles = 0;
            checked_o    = 1'b0;
            after_reset  = 1'b1;
        end else begin
            if (after_reset) begin
                compare_value("retire_valid_o", 32'd0, 32'(retire_valid_i));
                compare_value("inst_ready_o", 32'd1, 32'(inst_ready_i));
                after_reset = 1'b0;
            end
            if (!inst_ready_i) begin
                stall_cycles++;
            end
            if (retire_valid_i) begin
                check_retire();
            end
            if (inst_valid_i && inst_ready_i) begin
                accept_word();
            end
            if (done_i && !checked_o) begin
                final_checks();
            end
        end
        pending_o = exp_q.size();
    end

endmodule

/* sim/tb_clock.sv */
`timescale 1ns/1ns

module tb_clock (
    output logic clk_o,
    output logic reset_o
);

    initial begin
        clk_o = 1'b0;
        forever #5 clk_o = ~clk_o;
    end

    // sync reset, released just after the 16th rising edge
    initial begin
        reset_o = 1'b1;
        repeat (16) @(posedge clk_o);
        #1 reset_o = 1'b0;
    end

endmodule

/* sim/tb_core.sv */
`timescale 1ns/1ns

`include "core_config.svh"

module tb_core;

    localparam int READY_TIMEOUT = 50;
    localparam int DRAIN_TIMEOUT = 100;
    localparam int RESET_TIMEOUT = 100;

    // one stimulus row with the retire it should produce
    typedef struct packed {
        logic [31:0]       word;
        logic [2:0]        gap;
        logic              jitter;
        core_pkg::retire_t exp_ret;
    } stim_t;

    logic              clk;
    logic              reset;
    logic              inst_valid;
    logic [31:0]       inst_word;
    logic              inst_ready;
    logic              retire_valid;
    core_pkg::retire_t retire;
    core_pkg::xlen_t   gp;
    core_pkg::retire_t table_exp;
    logic              done;
    logic              checked;
    logic              timed_out;
    int                pending;
    int                value_errs;
    int                other_errs;
    int                accepted;
    int                retired;
    stim_t             program_q [$];

    tb_clock u_clock (
        .clk_o   (clk),
        .reset_o (reset)
    );

    core_top dut_i (
        .clk            (clk),
        .reset_i        (reset),
        .inst_valid_i   (inst_valid),
        .inst_i         (inst_word),
        .inst_ready_o   (inst_ready),
        .retire_valid_o (retire_valid),
        .retire_o       (retire),
        .gp_o           (gp)
    );

    core_checker u_checker (
        .clk            (clk),
        .reset_i        (reset),
        .inst_valid_i   (inst_valid),
        .inst_i         (inst_word),
        .inst_ready_i   (inst_ready),
        .table_exp_i    (table_exp),
        .retire_valid_i (retire_valid),
        .retire_i       (retire),
        .gp_i           (gp),
        .done_i         (done),
        .pending_o      (pending),
        .value_errs_o   (value_errs),
        .other_errs_o   (other_errs),
        .accepted_o     (accepted),
        .retired_o      (retired),
        .checked_o      (checked)
    );

    function automatic logic [31:0] r_word(input logic [6:0] f7, input logic [2:0] f3,
                                           input logic [4:0] rd, input logic [4:0] rs1,
                                           input logic [4:0] rs2);
        return {f7, rs2, rs1, f3, rd, `CORE_OP_REG};
    endfunction

    function automatic logic [31:0] i_word(input logic [2:0] f3, input logic [4:0] rd,
                                           input logic [4:0] rs1, input logic [11:0] imm);
        return {imm, rs1, f3, rd, `CORE_OP_IMM};
    endfunction

    function automatic logic [31:0] lui_word(input logic [4:0] rd, input logic [19:0] imm);
        return {imm, rd, `CORE_OP_LUI};
    endfunction

    // exp_rd of 0 means the word retires without a write
    function automatic void push_entry(input logic [31:0] word, input int gap,
                                       input logic jitter, input logic [4:0] exp_rd,
                                       input logic [31:0] exp_data);
        stim_t entry;
        entry.word          = word;
        entry.gap           = 3'(gap);
        entry.jitter        = jitter;
        entry.exp_ret.rd    = exp_rd;
        entry.exp_ret.wen   = (exp_rd != 5'd0);
        entry.exp_ret.wdata = exp_data;
        program_q.push_back(entry);
    endfunction

    function automatic void build_table();
        // independent alu ops and lui, random gaps allowed
        push_entry(i_word(`CORE_F3_ADD, 5'd1, 5'd0, 12'd5), 1, 1'b1, 5'd1, 32'd5);
        push_entry(i_word(`CORE_F3_ADD, 5'd2, 5'd0, 12'hffd), 0, 1'b1, 5'd2, 32'hffff_fffd);
        push_entry(lui_word(5'd4, 20'h12345), 0, 1'b1, 5'd4, 32'h1234_5000);
        push_entry(i_word(`CORE_F3_OR, 5'd6, 5'd0, 12'h0f0), 0, 1'b1, 5'd6, 32'h0f0);
        push_entry(i_word(`CORE_F3_XOR, 5'd7, 5'd0, 12'h7ff), 0, 1'b1, 5'd7, 32'h7ff);
        push_entry(r_word(`CORE_F7_BASE, `CORE_F3_ADD, 5'd8, 5'd1, 5'd4), 0, 1'b1,
                   5'd8, 32'h1234_5005);
        push_entry(r_word(`CORE_F7_SUB, `CORE_F3_ADD, 5'd9, 5'd0, 5'd1), 0, 1'b1,
                   5'd9, 32'hffff_fffb);
        push_entry(r_word(`CORE_F7_BASE, `CORE_F3_AND, 5'd10, 5'd7, 5'd6), 0, 1'b1,
                   5'd10, 32'h0f0);
        push_entry(r_word(`CORE_F7_BASE, `CORE_F3_XOR, 5'd11, 5'd6, 5'd7), 0, 1'b1,
                   5'd11, 32'h70f);
        push_entry(r_word(`CORE_F7_BASE, `CORE_F3_SLT, 5'd12, 5'd2, 5'd1), 0, 1'b1,
                   5'd12, 32'd1);
        push_entry(r_word(`CORE_F7_BASE, `CORE_F3_SLT, 5'd13, 5'd1, 5'd2), 0, 1'b1,
                   5'd13, 32'd0);
        push_entry(i_word(`CORE_F3_AND, 5'd14, 5'd2, 12'h0ff), 0, 1'b1, 5'd14, 32'h0fd);
        // back to back chain, each word needs its predecessor
        push_entry(i_word(`CORE_F3_ADD, 5'd3, 5'd0, 12'd1), 2, 1'b0, 5'd3, 32'd1);
        push_entry(i_word(`CORE_F3_ADD, 5'd3, 5'd3, 12'd2), 0, 1'b0, 5'd3, 32'd3);
        push_entry(r_word(`CORE_F7_BASE, `CORE_F3_ADD, 5'd3, 5'd3, 5'd3), 0, 1'b0,
                   5'd3, 32'd6);
        push_entry(r_word(`CORE_F7_SUB, `CORE_F3_ADD, 5'd15, 5'd3, 5'd1), 0, 1'b0,
                   5'd15, 32'd1);
        push_entry(r_word(`CORE_F7_BASE, `CORE_F3_OR, 5'd16, 5'd1, 5'd15), 0, 1'b0,
                   5'd16, 32'd5);
        // two apart uses the wb bypass, three apart the register file
        push_entry(i_word(`CORE_F3_ADD, 5'd17, 5'd0, 12'd100), 0, 1'b0, 5'd17, 32'd100);
        push_entry(i_word(`CORE_F3_ADD, 5'd18, 5'd0, 12'd7), 0, 1'b0, 5'd18, 32'd7);
        push_entry(r_word(`CORE_F7_BASE, `CORE_F3_ADD, 5'd19, 5'd17, 5'd17), 0, 1'b0,
                   5'd19, 32'd200);
        push_entry(r_word(`CORE_F7_BASE, `CORE_F3_SLT, 5'd20, 5'd18, 5'd17), 0, 1'b0,
                   5'd20, 32'd1);
        // x0 writes and unsupported words
        push_entry(i_word(`CORE_F3_ADD, 5'd0, 5'd1, 12'd55), 0, 1'b0, 5'd0, 32'd0);
        push_entry(r_word(`CORE_F7_BASE, `CORE_F3_ADD, 5'd21, 5'd0, 5'd1), 0, 1'b0,
                   5'd21, 32'd5);
        push_entry(32'h0000_0073, 0, 1'b0, 5'd0, 32'd0);
        push_entry(i_word(`CORE_F3_SLT, 5'd22, 5'd1, 12'd1), 0, 1'b0, 5'd0, 32'd0);
        push_entry(i_word(`CORE_F3_ADD, 5'd23, 5'd22, 12'd0), 0, 1'b0, 5'd23, 32'd0);
        push_entry(i_word(`CORE_F3_ADD, 5'd3, 5'd3, 12'h010), 1, 1'b0, 5'd3, 32'h16);
    endfunction

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic wait_reset();
        int waited;
        waited = 0;
        @(posedge clk);
        #1;
        while (reset && waited < RESET_TIMEOUT) begin
            @(posedge clk);
            #1;
            waited++;
        end
        if (reset) begin
            $display("timeout: reset was never released");
            timed_out = 1'b1;
        end
    endtask

    // ready depends on pipeline state only, so it is settled here
    task automatic send_word(input stim_t entry);
        int waited;
        waited     = 0;
        inst_valid = 1'b1;
        inst_word  = entry.word;
        table_exp  = entry.exp_ret;
        while (!inst_ready && waited < READY_TIMEOUT) begin
            @(posedge clk);
            #1;
            waited++;
        end
        if (!inst_ready) begin
            $display("timeout: inst_ready_o stayed low for %0d cycles", waited);
            timed_out = 1'b1;
        end else begin
            @(posedge clk);
            #1;
        end
        inst_valid = 1'b0;
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        while (pending != 0 && waited < DRAIN_TIMEOUT) begin
            @(posedge clk);
            #1;
            waited++;
        end
        if (pending != 0) begin
            $display("timeout: %0d instructions never retired", pending);
            timed_out = 1'b1;
        end
    endtask

    task automatic finish_checks();
        int waited;
        waited = 0;
        done   = 1'b1;
        while (!checked && waited < READY_TIMEOUT) begin
            @(posedge clk);
            #1;
            waited++;
        end
        if (!checked) begin
            $display("timeout: checker never finished its closing checks");
            timed_out = 1'b1;
        end
        done = 1'b0;
    endtask

    initial begin
        int extra;
        inst_valid = 1'b0;
        inst_word  = '0;
        table_exp  = '0;
        done       = 1'b0;
        timed_out  = 1'b0;
        void'($urandom(63));
        build_table();
        wait_reset();
        foreach (program_q[i]) begin
            if (!timed_out) begin
                extra = program_q[i].jitter ? int'($urandom % 3) : 0;
                idle_cycles(int'(program_q[i].gap) + extra);
                send_word(program_q[i]);
            end
        end
        if (!timed_out) begin
            wait_drain();
        end
        if (!timed_out) begin
            // a few quiet cycles to catch stray retires
            idle_cycles(4);
            finish_checks();
        end
        $display("errors: %0d value, %0d other; accepted %0d, retired %0d",
                 value_errs, other_errs, accepted, retired);
        if (timed_out || value_errs != 0 || other_errs != 0) begin
            $display("Some tests failed");
        end else begin
            $display("All tests passed");
        end
        $finish;
    end

endmodule

/* tb.f */
+incdir+hw
hw/core_pkg.sv
hw/pipe_stage_reg.sv
hw/decode_unit.sv
hw/operand_select.sv
hw/execute_unit.sv
hw/writeback_regfile.sv
hw/core_top.sv
sim/tb_clock.sv
sim/core_checker.sv
sim/tb_core.sv
